/* compile.f */
+incdir+hdl
hdl/qpu_pkg.sv
hdl/qpu_exu_decode.sv
hdl/qpu_exu_regfile.sv
hdl/qpu_exu_meas_track.sv
hdl/qpu_exu_disp.sv
hdl/qpu_exu_event_queue.sv
hdl/qpu_exu.sv
tests/qpu_exu_tb.sv

/* Makefile */
# Verilator build and run of the QPU execution stage testbench

VERILATOR ?= verilator
TOP       ?= qpu_exu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and search $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation did not complete, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/qpu_exu_tb.sv */
//////////////////////////////////////////////////
// QPU execution stage testbench
// Drives instructions, measurement results and the
// time base, and checks the DUT against a model
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "qpu_consts.svh"

module qpu_exu_tb;

  localparam int CLK_PERIOD      = 100;
  localparam int DRV             = 1;     // Input drive delay after the rising edge
  localparam int DEPTH           = `QPU_EVQ_DEPTH;
  localparam int N_INSTR         = 64;
  localparam int N_RUNS          = 4;     // Trigger runs
  localparam int MAX_TP          = 64;
  localparam int MARGIN          = 100;
  localparam int WATCHDOG_CYCLES = N_INSTR + N_RUNS * MAX_TP + MARGIN;

  logic                 clk;
  logic                 i_reset;
  logic                 i_valid;
  logic                 o_ready;
  qpu_pkg::instr_t      i_instr;
  logic                 o_halt;
  logic                 i_mcu_wen;
  qpu_pkg::qubit_mask_t i_mcu_measurement;
  logic                 i_trigger;
  qpu_pkg::time_t       i_trigger_clk;
  logic                 o_trigger_clk_ena;
  qpu_pkg::event_mask_t o_trigger_valid;
  qpu_pkg::event_data_t o_trigger_data;
  logic                 o_exu_active;

  // Reference model
  qpu_pkg::time_t       ev_time [$];
  qpu_pkg::event_mask_t ev_mask [$];
  qpu_pkg::event_data_t ev_data [$];
  qpu_pkg::time_t       m_time;
  qpu_pkg::qubit_mask_t m_out;      // Outstanding qubits
  qpu_pkg::qubit_mask_t m_res;      // Stored results
  logic                 m_ena;
  logic                 m_halted;
  int                   fail_count;
  integer               seed = 32'h5a04c9e4;

  qpu_exu qpu_exu_i (
    .clk               (clk              ),
    .i_reset           (i_reset          ),
    .i_valid           (i_valid          ),
    .o_ready           (o_ready          ),
    .i_instr           (i_instr          ),
    .o_halt            (o_halt           ),
    .i_mcu_wen         (i_mcu_wen        ),
    .i_mcu_measurement (i_mcu_measurement),
    .i_trigger         (i_trigger        ),
    .i_trigger_clk     (i_trigger_clk    ),
    .o_trigger_clk_ena (o_trigger_clk_ena),
    .o_trigger_valid   (o_trigger_valid  ),
    .o_trigger_data    (o_trigger_data   ),
    .o_exu_active      (o_exu_active     )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Time base restarts from zero while disabled
  always @(posedge clk) begin
    #DRV;
    if (i_reset || !o_trigger_clk_ena) begin
      i_trigger_clk = '0;
    end else begin
      i_trigger_clk = i_trigger_clk + 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////////////////////////
  // Failure reporting and field decode
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_count++;
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    $display("Errors found");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic report_failure(input string msg);
    fail_count++;
    $display("Failure: %s at %0t", msg, $time);
    $display("Errors found");
    $fatal(1, "Stopping at first failure");
  endtask

  function automatic logic is_conditional(input qpu_pkg::instr_t w);
    return (w[23:22] == 2'd1) || (w[23:22] == 2'd2);
  endfunction

  function automatic logic cond_holds(input qpu_pkg::instr_t w, input logic res);
    case (w[23:22])
      2'd1:    return res;
      2'd2:    return !res;
      default: return 1'b1;       // Always and the unused code 3
    endcase
  endfunction

  function automatic logic expect_ready(input qpu_pkg::instr_t w);
    logic [1:0] idx;
    logic       full;
    idx  = w[21:20];
    full = (ev_time.size() == DEPTH);
    if (m_halted) return 1'b0;
    if (w[31:28] == `QPU_OP_QEVENT) begin
      if (is_conditional(w) && m_out[idx]) return 1'b0;  // Result still pending
      if (cond_holds(w, m_res[idx]) && full) return 1'b0;
    end
    if (w[31:28] == `QPU_OP_QMEAS && |(m_out & w[3:0])) return 1'b0;
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Output checks and model update at mid cycle
  always @(negedge clk) begin : monitor
    logic                 rel;
    logic                 acc;
    logic                 push;
    logic                 exp_active;
    logic [1:0]           idx;
    qpu_pkg::event_mask_t exp_valid;
    if (i_reset) begin
      ev_time.delete();
      ev_mask.delete();
      ev_data.delete();
      m_time   = '0;
      m_out    = '0;
      m_res    = '0;
      m_ena    = 1'b0;
      m_halted = 1'b0;
    end else begin
      rel        = m_ena && (ev_time.size() != 0) && (i_trigger_clk >= ev_time[0]);
      exp_valid  = rel ? ev_mask[0] : '0;
      exp_active = (ev_time.size() != 0) || (|m_out) || i_valid;
      idx        = i_instr[21:20];
      assert (o_halt == m_halted)
        else report_mismatch("o_halt", 32'(o_halt), 32'(m_halted));
      assert (o_trigger_clk_ena == m_ena)
        else report_mismatch("o_trigger_clk_ena", 32'(o_trigger_clk_ena), 32'(m_ena));
      assert (o_trigger_valid == exp_valid)
        else report_mismatch("o_trigger_valid", 32'(o_trigger_valid), 32'(exp_valid));
      if (rel) begin
        assert (o_trigger_data == ev_data[0])
          else report_mismatch("o_trigger_data", 32'(o_trigger_data), 32'(ev_data[0]));
      end
      assert (o_ready == expect_ready(i_instr))
        else report_mismatch("o_ready", 32'(o_ready), 32'(expect_ready(i_instr)));
      assert (o_exu_active == exp_active)
        else report_mismatch("o_exu_active", 32'(o_exu_active), 32'(exp_active));

      acc  = i_valid && o_ready;
      push = acc && (i_instr[31:28] == `QPU_OP_QEVENT) && cond_holds(i_instr, m_res[idx]);
      if (i_trigger) begin
        m_ena = 1'b1;
      end else if (rel && ev_time.size() == 1 && !push) begin
        m_ena = 1'b0;                                   // Last entry leaves
      end
      if (rel) begin
        void'(ev_time.pop_front());
        void'(ev_mask.pop_front());
        void'(ev_data.pop_front());
      end
      if (push) begin
        ev_time.push_back(m_time);
        ev_mask.push_back(i_instr[27:24]);
        ev_data.push_back(i_instr[7:0]);
      end
      if (acc && i_instr[31:28] == `QPU_OP_QTIME) m_time = i_instr[15:0];
      if (i_mcu_wen) begin
        m_res = (m_res & ~m_out) | (i_mcu_measurement & m_out);
        m_out = '0;
      end
      if (acc && i_instr[31:28] == `QPU_OP_QMEAS) m_out = m_out | i_instr[3:0];
      if (acc && i_instr[31:28] == `QPU_OP_QHALT) m_halted = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Instruction words and random values
  function automatic qpu_pkg::instr_t mk_time(input qpu_pkg::time_t tp);
    return {`QPU_OP_QTIME, 12'h000, tp};
  endfunction

  function automatic qpu_pkg::instr_t mk_event(input logic [3:0] mask, input logic [1:0] cond,
                                               input logic [1:0] idx, input logic [7:0] data);
    return {`QPU_OP_QEVENT, mask, cond, idx, 12'h000, data};
  endfunction

  function automatic qpu_pkg::instr_t mk_meas(input logic [3:0] list);
    return {`QPU_OP_QMEAS, 24'h000000, list};
  endfunction

  function automatic logic [3:0] rand_mask();
    return 4'(($unsigned($random(seed)) % 15) + 1);  // Never zero
  endfunction

  function automatic logic [7:0] rand_data();
    return 8'($random(seed));
  endfunction

  function automatic qpu_pkg::time_t rand_step();
    return 16'(($unsigned($random(seed)) % 12) + 1);
  endfunction

  //////////////////////////////////////////////////
  // Drivers
  task automatic next_cycle();
    @(posedge clk);
    #DRV;
  endtask

  // Hold the instruction until the handshake completes
  task automatic issue(input qpu_pkg::instr_t instr);
    logic ok;
    ok      = 1'b0;
    i_valid = 1'b1;
    i_instr = instr;
    while (!ok) begin
      @(negedge clk);
      ok = o_ready;
      next_cycle();
    end
    i_valid = 1'b0;
    i_instr = '0;
  endtask

  task automatic present_stalled(input qpu_pkg::instr_t instr, input int cycles);
    i_valid = 1'b1;
    i_instr = instr;
    repeat (cycles) begin
      @(negedge clk);
      assert (!o_ready) else report_mismatch("o_ready", 32'(o_ready), 32'h0);
      next_cycle();
    end
    i_valid = 1'b0;
    i_instr = '0;
  endtask

  task automatic pulse_result(input qpu_pkg::qubit_mask_t meas);
    i_mcu_wen         = 1'b1;
    i_mcu_measurement = meas;
    next_cycle();
    i_mcu_wen         = 1'b0;
  endtask

  task automatic fire_trigger();
    i_trigger = 1'b1;
    next_cycle();
    i_trigger = 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(negedge clk);
    end while (o_trigger_clk_ena);
    next_cycle();
  endtask

  task automatic queue_events(input int n);
    qpu_pkg::time_t tp;
    tp = '0;
    for (int i = 0; i < n; i++) begin
      tp = tp + rand_step();
      issue(mk_time(tp));
      issue(mk_event(rand_mask(), `QPU_COND_ALWAYS, 2'd0, rand_data()));
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequences
  task automatic check_reset_state();
    @(negedge clk);
    assert (!o_trigger_clk_ena) else report_failure("time base enabled after reset");
    assert (o_trigger_valid == '0) else report_failure("trigger output active after reset");
    assert (!o_halt) else report_failure("halt set after reset");
    assert (o_ready) else report_failure("NOP not ready after reset");
    assert (!o_exu_active) else report_failure("unit active while idle after reset");
    next_cycle();
    issue('0);
  endtask

  task automatic run_meas_hazards();
    logic [1:0] q;
    q = 2'($unsigned($random(seed)) % 4);
    issue(mk_time(16'd4));
    issue(mk_meas(4'b0001 << q));
    fork
      issue(mk_event(rand_mask(), `QPU_COND_IF_ONE, q, rand_data()));
      begin
        repeat (4) next_cycle();
        pulse_result(4'($random(seed)));
      end
    join
    issue(mk_meas(4'b0001 << (q + 2'd1)));
    fork
      issue(mk_event(rand_mask(), `QPU_COND_IF_ZERO, q + 2'd1, rand_data()));
      begin
        repeat (3) next_cycle();
        pulse_result(4'($random(seed)));
      end
    join
    // Overlapping lists and a set at the retire edge
    issue(mk_meas(4'b0011));
    fork
      issue(mk_meas(4'b0110));
      begin
        repeat (3) next_cycle();
        pulse_result(4'($random(seed)));
      end
    join
    fork
      issue(mk_meas(4'b1000));
      pulse_result(4'($random(seed)));
    join
    pulse_result(4'($random(seed)));
    issue(mk_time(16'd20));
    issue(mk_event(rand_mask(), `QPU_COND_ALWAYS, 2'd0, rand_data()));
    fire_trigger();
    wait_drain();
  endtask

  task automatic run_back_pressure();
    queue_events(DEPTH);
    present_stalled(mk_event(rand_mask(), `QPU_COND_ALWAYS, 2'd0, rand_data()), 3);
    issue(mk_time(16'd62));
    // Condition fails, so it bypasses the full queue
    issue(mk_event(rand_mask(), m_res[0] ? `QPU_COND_IF_ZERO : `QPU_COND_IF_ONE,
                   2'd0, rand_data()));
    fork
      fire_trigger();
      issue(mk_event(rand_mask(), `QPU_COND_ALWAYS, 2'd0, rand_data()));
    join
    wait_drain();
  endtask

  task automatic run_halt();
    queue_events(2);
    issue({`QPU_OP_QHALT, 28'h0});
    present_stalled('0, 3);
    fire_trigger();
    wait_drain();
    @(negedge clk);
    assert (o_halt) else report_failure("halt dropped before reset");
    next_cycle();
  endtask

  initial begin
    clk               = 1'b0;
    i_reset           = 1'b1;
    i_valid           = 1'b0;
    i_instr           = '0;
    i_mcu_wen         = 1'b0;
    i_mcu_measurement = '0;
    i_trigger         = 1'b0;
    i_trigger_clk     = '0;
    fail_count        = 0;
    repeat (2) @(posedge clk);
    #DRV;
    i_reset = 1'b0;

    check_reset_state();
    queue_events(4);             // Timed release
    fire_trigger();
    wait_drain();
    run_meas_hazards();
    run_back_pressure();
    run_halt();

    @(negedge clk);
    assert (ev_time.size() == 0) else report_failure("expected events never released");
    if (fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* hdl/qpu_exu.sv */
//////////////////////////////////////////////////
// QPU execution stage
// Decode, dispatch, registers, measurement
// scoreboard and the timed event queue
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "qpu_consts.svh"

module qpu_exu (
  input  logic                 clk,
  input  logic                 i_reset,
  // Fetch handshake
  input  logic                 i_valid,
  output logic                 o_ready,
  input  qpu_pkg::instr_t      i_instr,
  output logic                 o_halt,
  // Measurement unit
  input  logic                 i_mcu_wen,
  input  qpu_pkg::qubit_mask_t i_mcu_measurement,
  // Trigger side
  input  logic                 i_trigger,
  input  qpu_pkg::time_t       i_trigger_clk,
  output logic                 o_trigger_clk_ena,
  output qpu_pkg::event_mask_t o_trigger_valid,
  output qpu_pkg::event_data_t o_trigger_data,
  output logic                 o_exu_active
);

  logic                 dec_is_time;
  logic                 dec_is_event;
  logic                 dec_is_meas;
  logic                 dec_is_halt;
  qpu_pkg::cond_e       dec_cond;
  qpu_pkg::qubit_idx_t  dec_qubit_idx;
  qpu_pkg::qubit_mask_t dec_qubit_list;
  qpu_pkg::event_mask_t dec_event_mask;
  qpu_pkg::event_data_t dec_event_data;
  qpu_pkg::time_t       dec_timepoint;

  logic                 time_wen;
  logic                 evq_push;
  logic                 meas_set;
  qpu_pkg::time_t       cur_time;
  logic                 qubit_result;
  qpu_pkg::qubit_mask_t outstanding;
  logic                 qubit_busy;
  logic                 list_busy;
  logic                 meas_empty;
  logic                 evq_full;
  logic                 evq_empty;

  //////////////////////////////////////////////////
  // Decode and dispatch
  qpu_exu_decode u_qpu_exu_decode (
    .i_instr      (i_instr       ),
    .o_is_time    (dec_is_time   ),
    .o_is_event   (dec_is_event  ),
    .o_is_meas    (dec_is_meas   ),
    .o_is_halt    (dec_is_halt   ),
    .o_cond       (dec_cond      ),
    .o_qubit_idx  (dec_qubit_idx ),
    .o_qubit_list (dec_qubit_list),
    .o_event_mask (dec_event_mask),
    .o_event_data (dec_event_data),
    .o_timepoint  (dec_timepoint )
  );

  qpu_exu_disp u_qpu_exu_disp (
    .clk            (clk         ),
    .i_reset        (i_reset     ),
    .i_valid        (i_valid     ),
    .o_ready        (o_ready     ),
    .i_is_time      (dec_is_time ),
    .i_is_event     (dec_is_event),
    .i_is_meas      (dec_is_meas ),
    .i_is_halt      (dec_is_halt ),
    .i_cond         (dec_cond    ),
    .i_qubit_result (qubit_result),
    .i_qubit_busy   (qubit_busy  ),
    .i_list_busy    (list_busy   ),
    .i_evq_full     (evq_full    ),
    .o_time_wen     (time_wen    ),
    .o_evq_push     (evq_push    ),
    .o_meas_set     (meas_set    ),
    .o_halt         (o_halt      )
  );

  //////////////////////////////////////////////////
  // State
  qpu_exu_regfile u_qpu_exu_regfile (
    .clk               (clk              ),
    .i_reset           (i_reset          ),
    .i_time_wen        (time_wen         ),
    .i_time_data       (dec_timepoint    ),
    .i_mcu_wen         (i_mcu_wen        ),
    .i_mcu_measurement (i_mcu_measurement),
    .i_outstanding     (outstanding      ),
    .i_qubit_idx       (dec_qubit_idx    ),
    .o_time            (cur_time         ),
    .o_qubit_result    (qubit_result     )
  );

  qpu_exu_meas_track u_qpu_exu_meas_track (
    .clk           (clk           ),
    .i_reset       (i_reset       ),
    .i_meas_set    (meas_set      ),
    .i_qubit_list  (dec_qubit_list),
    .i_mcu_wen     (i_mcu_wen     ),
    .i_qubit_idx   (dec_qubit_idx ),
    .o_outstanding (outstanding   ),
    .o_qubit_busy  (qubit_busy    ),
    .o_list_busy   (list_busy     ),
    .o_empty       (meas_empty    )
  );

  // Entry timepoint is the time register at push
  qpu_exu_event_queue #(
    .DEPTH (`QPU_EVQ_DEPTH)
  ) u_qpu_exu_event_queue (
    .clk               (clk              ),
    .i_reset           (i_reset          ),
    .i_push            (evq_push         ),
    .i_time            (cur_time         ),
    .i_mask            (dec_event_mask   ),
    .i_data            (dec_event_data   ),
    .o_full            (evq_full         ),
    .o_empty           (evq_empty        ),
    .i_trigger         (i_trigger        ),
    .i_trigger_clk     (i_trigger_clk    ),
    .o_trigger_clk_ena (o_trigger_clk_ena),
    .o_trigger_valid   (o_trigger_valid  ),
    .o_trigger_data    (o_trigger_data   )
  );

  assign o_exu_active = ~evq_empty | ~meas_empty | i_valid;

endmodule

/* hdl/qpu_exu_event_queue.sv */
//////////////////////////////////////////////////
// Timed event queue
// FIFO of {timepoint, mask, payload} entries, the
// time base enable and release to the triggers
//////////////////////////////////////////////////
`timescale 1ns/10ps

module qpu_exu_event_queue #(
  parameter int DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 i_reset,
  input  logic                 i_push,
  input  qpu_pkg::time_t       i_time,
  input  qpu_pkg::event_mask_t i_mask,
  input  qpu_pkg::event_data_t i_data,
  output logic                 o_full,
  output logic                 o_empty,
  input  logic                 i_trigger,
  input  qpu_pkg::time_t       i_trigger_clk,
  output logic                 o_trigger_clk_ena,
  output qpu_pkg::event_mask_t o_trigger_valid,
  output qpu_pkg::event_data_t o_trigger_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  qpu_pkg::time_t       time_mem [DEPTH];
  qpu_pkg::event_mask_t mask_mem [DEPTH];
  qpu_pkg::event_data_t data_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_ok;
  logic             release_ev;
  logic             clk_ena_q;

  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_empty = (count == '0);
  assign push_ok = i_push & ~o_full;

  //////////////////////////////////////////////////
  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      time_mem[wr_ptr] <= i_time;
      mask_mem[wr_ptr] <= i_mask;
      data_mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (release_ev) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, release_ev})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // Idle or push with pop
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Time base enable and release
  //
  // Trigger starts the time base, it stops when the
  // last entry leaves with no new one arriving
  always_ff @(posedge clk) begin
    if (i_reset) begin
      clk_ena_q <= 1'b0;
    end else if (i_trigger) begin
      clk_ena_q <= 1'b1;
    end else if (release_ev && count == CNT_W'(1) && !push_ok) begin
      clk_ena_q <= 1'b0;
    end
  end

  assign release_ev = clk_ena_q & ~o_empty & (i_trigger_clk >= time_mem[rd_ptr]);

  assign o_trigger_clk_ena = clk_ena_q;
  assign o_trigger_valid   = release_ev ? mask_mem[rd_ptr] : '0;  // One entry per cycle
  assign o_trigger_data    = release_ev ? data_mem[rd_ptr] : '0;

endmodule

/* hdl/qpu_exu_disp.sv */
//////////////////////////////////////////////////
// QPU dispatch
// Instruction handshake, stall logic, condition
// resolution, write strobes and the halt state
//////////////////////////////////////////////////
`timescale 1ns/10ps

module qpu_exu_disp (
  input  logic           clk,
  input  logic           i_reset,
  input  logic           i_valid,
  output logic           o_ready,
  input  logic           i_is_time,
  input  logic           i_is_event,
  input  logic           i_is_meas,
  input  logic           i_is_halt,
  input  qpu_pkg::cond_e i_cond,
  input  logic           i_qubit_result,
  input  logic           i_qubit_busy,
  input  logic           i_list_busy,
  input  logic           i_evq_full,
  output logic           o_time_wen,
  output logic           o_evq_push,
  output logic           o_meas_set,
  output logic           o_halt
);

  logic halt_q;
  logic cond_ok;
  logic cond_stall;
  logic meas_stall;
  logic full_stall;
  logic accept;

  // Event condition against the stored result bit
  always_comb begin
    case (i_cond)
      qpu_pkg::COND_IF_ONE:  cond_ok = i_qubit_result;
      qpu_pkg::COND_IF_ZERO: cond_ok = ~i_qubit_result;
      default:               cond_ok = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////
  // Stall conditions
  //
  // A conditional event waits for its qubit, since
  // the stored bit is stale until the result write
  assign cond_stall = i_is_event & (i_cond != qpu_pkg::COND_ALWAYS) & i_qubit_busy;
  assign meas_stall = i_is_meas & i_list_busy;
  assign full_stall = i_is_event & cond_ok & i_evq_full;  // Rejected events bypass the queue

  assign o_ready = ~halt_q & ~cond_stall & ~meas_stall & ~full_stall;
  assign accept  = i_valid & o_ready;

  //////////////////////////////////////////////////
  // Write strobes
  assign o_time_wen = accept & i_is_time;
  assign o_evq_push = accept & i_is_event & cond_ok;
  assign o_meas_set = accept & i_is_meas;

  // Halt holds until reset
  always_ff @(posedge clk) begin
    if (i_reset) begin
      halt_q <= 1'b0;
    end else if (accept & i_is_halt) begin
      halt_q <= 1'b1;
    end
  end

  assign o_halt = halt_q;

endmodule

/* hdl/qpu_exu_meas_track.sv */
//////////////////////////////////////////////////
// Measurement scoreboard
// Tracks qubits waiting for a result and flags
// hazards against the instruction in dispatch
//////////////////////////////////////////////////
`timescale 1ns/10ps

module qpu_exu_meas_track (
  input  logic                 clk,
  input  logic                 i_reset,
  input  logic                 i_meas_set,
  input  qpu_pkg::qubit_mask_t i_qubit_list,
  input  logic                 i_mcu_wen,
  input  qpu_pkg::qubit_idx_t  i_qubit_idx,
  output qpu_pkg::qubit_mask_t o_outstanding,
  output logic                 o_qubit_busy,
  output logic                 o_list_busy,
  output logic                 o_empty
);

  qpu_pkg::qubit_mask_t outstanding_q;
  qpu_pkg::qubit_mask_t kept;

  // A result write retires everything in flight
  assign kept = i_mcu_wen ? '0 : outstanding_q;

  // New QMEAS bits win over a retire at the same edge
  always_ff @(posedge clk) begin
    if (i_reset) begin
      outstanding_q <= '0;
    end else if (i_meas_set) begin
      outstanding_q <= kept | i_qubit_list;
    end else begin
      outstanding_q <= kept;
    end
  end

  //////////////////////////////////////////////////
  // Hazard matches
  assign o_qubit_busy  = outstanding_q[i_qubit_idx];        // Conditional event
  assign o_list_busy   = |(outstanding_q & i_qubit_list);   // Overlapping QMEAS
  assign o_empty       = ~|outstanding_q;
  assign o_outstanding = outstanding_q;

endmodule

/* hdl/qpu_exu_regfile.sv */
//////////////////////////////////////////////////
// QPU execution stage register file
// Current timepoint and measurement result bits
//////////////////////////////////////////////////
`timescale 1ns/10ps

module qpu_exu_regfile (
  input  logic                 clk,
  input  logic                 i_reset,
  input  logic                 i_time_wen,
  input  qpu_pkg::time_t       i_time_data,
  input  logic                 i_mcu_wen,
  input  qpu_pkg::qubit_mask_t i_mcu_measurement,
  input  qpu_pkg::qubit_mask_t i_outstanding,
  input  qpu_pkg::qubit_idx_t  i_qubit_idx,
  output qpu_pkg::time_t       o_time,
  output logic                 o_qubit_result
);

  qpu_pkg::time_t       time_q;
  qpu_pkg::qubit_mask_t result_q;

  // Absolute timepoint set by QTIME
  always_ff @(posedge clk) begin
    if (i_reset) begin
      time_q <= '0;
    end else if (i_time_wen) begin
      time_q <= i_time_data;
    end
  end

  //////////////////////////////////////////////////
  // Measurement results
  //
  // Only qubits outstanding before the write take a
  // new bit, all others keep the old result
  always_ff @(posedge clk) begin
    if (i_reset) begin
      result_q <= '0;
    end else if (i_mcu_wen) begin
      result_q <= (result_q & ~i_outstanding) |
                  (i_mcu_measurement & i_outstanding);
    end
  end

  assign o_time         = time_q;
  assign o_qubit_result = result_q[i_qubit_idx];  // Operand of a conditional event

endmodule

/* hdl/qpu_exu_decode.sv */
//////////////////////////////////////////////////
// QPU execution stage decoder
// Splits the instruction word into its fields and
// flags the instruction kind, purely combinational
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "qpu_consts.svh"

module qpu_exu_decode (
  input  qpu_pkg::instr_t      i_instr,
  output logic                 o_is_time,
  output logic                 o_is_event,
  output logic                 o_is_meas,
  output logic                 o_is_halt,
  output qpu_pkg::cond_e       o_cond,
  output qpu_pkg::qubit_idx_t  o_qubit_idx,
  output qpu_pkg::qubit_mask_t o_qubit_list,
  output qpu_pkg::event_mask_t o_event_mask,
  output qpu_pkg::event_data_t o_event_data,
  output qpu_pkg::time_t       o_timepoint
);

  qpu_pkg::opcode_e opcode;

  // Unknown opcodes fold to NOP
  always_comb begin
    case (i_instr[`QPU_F_OPC +: `QPU_OPC_W])
      qpu_pkg::OP_QTIME:  opcode = qpu_pkg::OP_QTIME;
      qpu_pkg::OP_QEVENT: opcode = qpu_pkg::OP_QEVENT;
      qpu_pkg::OP_QMEAS:  opcode = qpu_pkg::OP_QMEAS;
      qpu_pkg::OP_QHALT:  opcode = qpu_pkg::OP_QHALT;
      default:            opcode = qpu_pkg::OP_NOP;
    endcase
  end

  // Code 3 is not defined, treat as unconditional
  always_comb begin
    case (i_instr[`QPU_F_COND +: `QPU_COND_W])
      qpu_pkg::COND_IF_ONE:  o_cond = qpu_pkg::COND_IF_ONE;
      qpu_pkg::COND_IF_ZERO: o_cond = qpu_pkg::COND_IF_ZERO;
      default:               o_cond = qpu_pkg::COND_ALWAYS;
    endcase
  end

  assign o_is_time  = (opcode == qpu_pkg::OP_QTIME);
  assign o_is_event = (opcode == qpu_pkg::OP_QEVENT);
  assign o_is_meas  = (opcode == qpu_pkg::OP_QMEAS);
  assign o_is_halt  = (opcode == qpu_pkg::OP_QHALT);

  //////////////////////////////////////////////////
  // Operand fields, overlapping by design
  assign o_qubit_idx  = i_instr[`QPU_F_QIDX +: `QPU_QIDX_W];
  assign o_qubit_list = i_instr[`QPU_F_QLIST +: `QPU_QUBIT_NUM];  // QMEAS only
  assign o_event_mask = i_instr[`QPU_F_MASK +: `QPU_EVENT_NUM];
  assign o_event_data = i_instr[`QPU_F_DATA +: `QPU_EVENT_DATA_W];
  assign o_timepoint  = i_instr[`QPU_F_TIME +: `QPU_TIME_W];       // QTIME only

endmodule

/* hdl/qpu_pkg.sv */
//////////////////////////////////////////////////
// QPU execution stage types
// Vector types for the meaningful widths and the
// opcode and condition encodings
//////////////////////////////////////////////////
`include "qpu_consts.svh"

package qpu_pkg;

  typedef logic [`QPU_INSTR_W-1:0]      instr_t;      // Instruction word
  typedef logic [`QPU_TIME_W-1:0]       time_t;       // Timepoint / time base
  typedef logic [`QPU_EVENT_NUM-1:0]    event_mask_t; // One bit per trigger channel
  typedef logic [`QPU_EVENT_DATA_W-1:0] event_data_t; // Event payload
  typedef logic [`QPU_QUBIT_NUM-1:0]    qubit_mask_t; // One bit per qubit
  typedef logic [`QPU_QIDX_W-1:0]       qubit_idx_t;  // Qubit number

  typedef enum logic [`QPU_OPC_W-1:0] {
    OP_NOP    = `QPU_OP_NOP,
    OP_QTIME  = `QPU_OP_QTIME,
    OP_QEVENT = `QPU_OP_QEVENT,
    OP_QMEAS  = `QPU_OP_QMEAS,
    OP_QHALT  = `QPU_OP_QHALT
  } opcode_e;

  // Condition of a QEVENT on a measured qubit
  typedef enum logic [`QPU_COND_W-1:0] {
    COND_ALWAYS  = `QPU_COND_ALWAYS,
    COND_IF_ONE  = `QPU_COND_IF_ONE,
    COND_IF_ZERO = `QPU_COND_IF_ZERO
  } cond_e;

endpackage

/* hdl/qpu_consts.svh */
//////////////////////////////////////////////////
// QPU execution stage constants
// Widths, queue depth, opcode and condition codes
// and the instruction field positions
//////////////////////////////////////////////////
`ifndef QPU_CONSTS_SVH
`define QPU_CONSTS_SVH

`define QPU_INSTR_W       32
`define QPU_TIME_W        16
`define QPU_EVENT_NUM     4
`define QPU_EVENT_DATA_W  8
`define QPU_QUBIT_NUM     4
`define QPU_QIDX_W        2
`define QPU_EVQ_DEPTH     4

`define QPU_OPC_W         4
`define QPU_COND_W        2

// Opcode values
`define QPU_OP_NOP        4'd0
`define QPU_OP_QTIME      4'd1
`define QPU_OP_QEVENT     4'd2
`define QPU_OP_QMEAS      4'd3
`define QPU_OP_QHALT      4'd4

// Event condition values, 3 folds to always
`define QPU_COND_ALWAYS   2'd0
`define QPU_COND_IF_ONE   2'd1
`define QPU_COND_IF_ZERO  2'd2

// Low bit of each instruction field
`define QPU_F_OPC         28
`define QPU_F_MASK        24
`define QPU_F_COND        22
`define QPU_F_QIDX        20
`define QPU_F_TIME        0
`define QPU_F_DATA        0
`define QPU_F_QLIST       0

`endif
